// File: mem_bridge_defines.svh
`ifndef MEM_BRIDGE_DEFINES_SVH
`define MEM_BRIDGE_DEFINES_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////
`define MB_DATA_W      32  // wishbone and memory port word
`define MB_ADDR_W      29  // byte address, 512 Mbytes
`define MB_BL_W        6   // burst length field holds length - 1
`define MB_CNT_W       7   // strobe / ack / words-left counters

//////////////////////////////////////////////////
// buffers and bursts
//////////////////////////////////////////////////
`define MB_WBUF_BITS   6   // write buffer, 64 words
`define MB_RBUF_BITS   4   // prefetch buffer, 16 words
`define MB_READ_BURST  8   // words fetched per read command
`define MB_WORD_BYTES  4   // byte address step per word

// memory port instructions, both with autoprecharge
`define MB_CMD_WR      3'b010
`define MB_CMD_RD      3'b011

`endif

// File: mem_bridge_pkg.sv
`include "mem_bridge_defines.svh"

package mem_bridge_pkg;

   //////////////////////////////////////////////////
   // payload types
   //////////////////////////////////////////////////
   typedef logic [`MB_DATA_W-1:0]   word_t;  // one data word
   typedef logic [`MB_ADDR_W-1:0]   addr_t;  // byte address
   typedef logic [`MB_DATA_W/8-1:0] mask_t;  // one bit per byte lane

   // memory command fields
   typedef logic [`MB_BL_W-1:0]     blen_t;  // burst length minus one
   typedef logic [2:0]              cmd_t;   // instruction code

   typedef logic [`MB_CNT_W-1:0]    cnt_t;   // per-block counters

   // block command machine
   typedef enum logic [2:0] {
      st_rst,       // wait for the cycle in progress to end
      st_idle,      // first strobe of a block decides direction
      st_wr_fill,   // words go into the write buffer
      st_wr_cmd,    // write command held off by cmd_full
      st_rd_serve,  // acks come out of the prefetch buffer
      st_rd_cmd     // read command held off by cmd_full
   } fsm_state_t;

endpackage

// File: port_fifo.sv
module port_fifo #(
   parameter int WIDTH      = 32,
   parameter int DEPTH_BITS = 4
) (
   input  logic             wb_clk,
   input  logic             mem_rst,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] head_o,
   output logic             empty_o,
   output logic             full_o
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];  // storage, no reset
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;        // one extra bit to tell full from empty
   logic                  do_push;
   logic                  do_pop;

   assign do_push = push_i & ~full_o;   // push into a full buffer is dropped
   assign do_pop  = pop_i & ~empty_o;

   always_ff @(posedge wb_clk) begin
      if (do_push) mem[wr_ptr] <= push_data_i;
   end

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // both or neither
         endcase
      end
   end

   // first word falls through
   assign head_o  = mem[rd_ptr];
   assign empty_o = (count == '0);
   assign full_o  = (count == (DEPTH_BITS + 1)'(DEPTH));

endmodule

// File: wb_port_front.sv
`include "mem_bridge_defines.svh"

module wb_port_front (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  logic                  wbm_cyc_i,
   input  logic                  wbm_stb_i,
   input  logic                  wbm_we_i,
   input  mem_bridge_pkg::mask_t wbm_sel_i,
   input  mem_bridge_pkg::word_t wbm_dat_i,
   input  logic                  cmd_full_i,
   input  logic                  wr_en_i,
   input  logic                  clr_cnt_i,
   output logic                  wbm_stall_o,
   output logic                  wr_ack_o,
   output logic                  accept_o,
   output mem_bridge_pkg::cnt_t  stb_cnt_o,
   output logic                  wbuf_full_o,
   output mem_bridge_pkg::word_t wr_data_o,
   output mem_bridge_pkg::mask_t wr_mask_o
);
   import mem_bridge_pkg::*;

   localparam int WBUF_W = $bits(mask_t) + $bits(word_t);  // mask rides above data

   mask_t             sel_n;      // memory port masks bytes out
   logic              wr_push;
   logic [WBUF_W-1:0] wbuf_head;
   cnt_t              stb_cnt;

   // stall on a full buffer or a busy command queue
   assign wbm_stall_o = wbuf_full_o | cmd_full_i;
   assign accept_o    = wbm_cyc_i & wbm_stb_i & ~wbm_stall_o;
   assign wr_push     = accept_o & wbm_we_i;
   assign sel_n       = ~wbm_sel_i;

   port_fifo #(
      .WIDTH      (WBUF_W),
      .DEPTH_BITS (`MB_WBUF_BITS)
   ) i_wbuf (
      .wb_clk      (wb_clk),
      .mem_rst     (mem_rst),
      .push_i      (wr_push),
      .push_data_i ({sel_n, wbm_dat_i}),
      .pop_i       (wr_en_i),      // memory pulls one word per strobe
      .head_o      (wbuf_head),
      .empty_o     (),
      .full_o      (wbuf_full_o)
   );

   assign {wr_mask_o, wr_data_o} = wbuf_head;

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         wr_ack_o <= 1'b0;
         stb_cnt  <= '0;
      end else begin
         wr_ack_o <= wr_push;  // writes ack right after acceptance
         if (clr_cnt_i) stb_cnt <= cnt_t'(accept_o);  // idle restarts the block count
         else if (accept_o) stb_cnt <= stb_cnt + 1'b1;
      end
   end

   assign stb_cnt_o = stb_cnt;

endmodule

// File: block_cmd_fsm.sv
`include "mem_bridge_defines.svh"

module block_cmd_fsm (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  logic                  wbm_cyc_i,
   input  logic                  wbm_stb_i,
   input  logic                  wbm_we_i,
   input  mem_bridge_pkg::addr_t wbm_addr_i,
   input  logic                  accept_i,
   input  mem_bridge_pkg::cnt_t  stb_cnt_i,
   input  logic                  wbuf_full_i,
   input  logic                  cmd_full_i,
   input  logic                  hit_i,
   input  logic                  rbuf_empty_i,
   input  logic                  flush_busy_i,
   input  mem_bridge_pkg::word_t rd_word_i,
   output logic                  clr_cnt_o,
   output logic                  pop_o,
   output logic                  flush_o,
   output logic                  flush_rd_o,
   output mem_bridge_pkg::addr_t expect_addr_o,
   output logic                  rd_ack_o,
   output mem_bridge_pkg::word_t wbm_dat_o,
   output logic                  cmd_en_o,
   output mem_bridge_pkg::cmd_t  cmd_instr_o,
   output mem_bridge_pkg::blen_t cmd_bl_o,
   output mem_bridge_pkg::addr_t cmd_addr_o
);
   import mem_bridge_pkg::*;

   fsm_state_t state;
   cnt_t       ack_cnt;     // read acks given in this block
   addr_t      adr_beg;     // start of the last burst
   addr_t      adr_next;    // address of the word at the prefetch head
   addr_t      burst_end;   // first address past the last read burst
   logic       flushing;    // flush requested or still draining
   logic       rd_pending;  // an accepted read still owes an ack
   logic       hit_take;
   logic       serve;
   logic       rd_miss;
   logic       refill;
   logic       wr_done;

   assign burst_end  = adr_beg + addr_t'(`MB_READ_BURST * `MB_WORD_BYTES);
   assign flushing   = flush_busy_i | flush_o;  // covers the cycle before busy rises
   assign rd_pending = (ack_cnt != stb_cnt_i) | accept_i;

   //////////////////////////////////////////////////
   // decisions
   //////////////////////////////////////////////////
   assign hit_take = (state == st_idle) & accept_i & ~wbm_we_i & hit_i & ~flushing;
   assign rd_miss  = (state == st_idle) & accept_i & ~wbm_we_i & ~hit_take;
   assign serve    = (state == st_rd_serve) & wbm_cyc_i & rd_pending
                     & ~flushing & ~rbuf_empty_i;
   // buffer ran dry in mid-block, fetch the next burst
   assign refill   = (state == st_rd_serve) & wbm_cyc_i & rd_pending & rbuf_empty_i
                     & ~flushing & (adr_next == burst_end);
   assign wr_done  = (state == st_wr_fill) & (wbuf_full_i | ~wbm_cyc_i);

   assign pop_o         = hit_take | serve;  // same cycle as the registered ack
   assign clr_cnt_o     = (state == st_idle);
   assign expect_addr_o = adr_next;
   assign cmd_addr_o    = adr_beg;

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state    <= st_rst;
         ack_cnt  <= '0;
         cmd_en_o <= 1'b0;
         rd_ack_o <= 1'b0;
         flush_o  <= 1'b0;
      end else begin
         cmd_en_o <= 1'b0;  // strobes
         rd_ack_o <= 1'b0;
         flush_o  <= 1'b0;
         if (pop_o) begin
            rd_ack_o  <= 1'b1;
            wbm_dat_o <= rd_word_i;
            ack_cnt   <= ack_cnt + 1'b1;
            adr_next  <= adr_next + addr_t'(`MB_WORD_BYTES);
         end
         // new read burst, stale words flushed first
         if (rd_miss || refill) begin
            flush_o     <= 1'b1;
            flush_rd_o  <= 1'b1;
            cmd_instr_o <= `MB_CMD_RD;
            cmd_bl_o    <= blen_t'(`MB_READ_BURST - 1);
            cmd_en_o    <= ~cmd_full_i;
            state       <= cmd_full_i ? st_rd_cmd : st_rd_serve;
            if (rd_miss) begin
               adr_beg  <= wbm_addr_i;
               adr_next <= wbm_addr_i;  // head once the flush is done
            end else begin
               adr_beg <= adr_next;
            end
         end
         // write block closes, prefetch data may now be old
         if (wr_done) begin
            flush_o     <= 1'b1;
            flush_rd_o  <= 1'b0;
            cmd_instr_o <= `MB_CMD_WR;
            cmd_bl_o    <= blen_t'(stb_cnt_i - 1'b1);
            cmd_en_o    <= ~cmd_full_i;
            state       <= cmd_full_i ? st_wr_cmd : st_idle;
         end
         case (state)
            st_rst: if (~wbm_cyc_i) state <= st_idle;
            st_idle: begin
               ack_cnt <= cnt_t'(hit_take);  // block starts with zero or one ack
               if (accept_i && wbm_we_i) begin
                  adr_beg <= wbm_addr_i;
                  state   <= st_wr_fill;
               end else if (hit_take) begin
                  state <= st_rd_serve;
               end
            end
            st_wr_cmd, st_rd_cmd: begin
               if (~cmd_full_i) begin
                  cmd_en_o <= 1'b1;
                  state    <= (state == st_wr_cmd) ? st_idle : st_rd_serve;
               end
            end
            st_rd_serve: begin
               if (~wbm_cyc_i || (~rd_pending && ~wbm_stb_i)) state <= st_idle;
            end
            default: ;  // st_wr_fill exits through wr_done
         endcase
      end
   end

endmodule

// File: read_prefetch.sv
`include "mem_bridge_defines.svh"

module read_prefetch (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  logic                  rd_vld_i,
   input  mem_bridge_pkg::word_t rd_data_i,
   input  logic                  pop_i,
   input  logic                  flush_i,
   input  logic                  flush_rd_i,
   input  mem_bridge_pkg::addr_t expect_addr_i,
   input  mem_bridge_pkg::addr_t wbm_addr_i,
   output logic                  hit_o,
   output logic                  rbuf_empty_o,
   output logic                  flush_busy_o,
   output mem_bridge_pkg::word_t rd_word_o
);
   import mem_bridge_pkg::*;

   addr_t head_addr;   // byte address of the word at the head
   cnt_t  words_left;  // words buffered or still in flight
   logic  flush_rd_q;  // flush came from a read, reload a full burst
   logic  fifo_empty;
   logic  drain;       // drop one stale word
   logic  fifo_pop;

   // stale words may still be on their way, drain only what is there
   assign drain    = flush_busy_o & ~fifo_empty & (words_left != '0);
   assign fifo_pop = drain | pop_i;

   port_fifo #(
      .WIDTH      (`MB_DATA_W),
      .DEPTH_BITS (`MB_RBUF_BITS)
   ) i_rbuf (
      .wb_clk      (wb_clk),
      .mem_rst     (mem_rst),
      .push_i      (rd_vld_i),  // no back-pressure toward the memory
      .push_data_i (rd_data_i),
      .pop_i       (fifo_pop),
      .head_o      (rd_word_o),
      .empty_o     (fifo_empty),
      .full_o      ()
   );

   assign rbuf_empty_o = fifo_empty;
   assign hit_o = (wbm_addr_i == head_addr) & ~fifo_empty & ~flush_busy_o;

   //////////////////////////////////////////////////
   // flush and head tracking
   //////////////////////////////////////////////////
   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         flush_busy_o <= 1'b0;
         words_left   <= '0;
      end else begin
         if (fifo_pop) words_left <= words_left - 1'b1;
         if (flush_i) begin
            flush_busy_o <= 1'b1;           // a second flush just extends the first
            flush_rd_q   <= flush_rd_i;
            head_addr    <= expect_addr_i;  // start of the burst to come
         end else if (flush_busy_o && words_left == '0) begin
            flush_busy_o <= 1'b0;
            words_left   <= flush_rd_q ? cnt_t'(`MB_READ_BURST) : '0;
         end else if (pop_i) begin
            head_addr <= head_addr + addr_t'(`MB_WORD_BYTES);
         end
      end
   end

endmodule

// File: wb_mem_bridge.sv
module wb_mem_bridge (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   // pipelined wishbone slave
   input  logic                  wbm_cyc_i,
   input  logic                  wbm_stb_i,
   input  logic                  wbm_we_i,
   input  mem_bridge_pkg::mask_t wbm_sel_i,
   input  mem_bridge_pkg::addr_t wbm_addr_i,
   input  mem_bridge_pkg::word_t wbm_dat_i,
   output logic                  wbm_ack_o,
   output logic                  wbm_stall_o,
   output mem_bridge_pkg::word_t wbm_dat_o,
   // memory command port
   output logic                  cmd_en_o,
   output mem_bridge_pkg::cmd_t  cmd_instr_o,
   output mem_bridge_pkg::blen_t cmd_bl_o,
   output mem_bridge_pkg::addr_t cmd_addr_o,
   input  logic                  cmd_full_i,
   // write pull and read push
   input  logic                  wr_en_i,
   output mem_bridge_pkg::word_t wr_data_o,
   output mem_bridge_pkg::mask_t wr_mask_o,
   input  logic                  rd_vld_i,
   input  mem_bridge_pkg::word_t rd_data_i
);
   import mem_bridge_pkg::*;

   logic  accept;
   cnt_t  stb_cnt;
   logic  wbuf_full;
   logic  wr_ack;
   logic  clr_cnt;
   logic  hit;
   logic  rbuf_empty;
   logic  flush_busy;
   word_t rd_word;
   logic  pop;
   logic  flush;
   logic  flush_rd;
   addr_t expect_addr;
   logic  rd_ack;

   assign wbm_ack_o = wr_ack | rd_ack;  // never both in one block

   wb_port_front i_front (
      .wb_clk, .mem_rst, .wbm_cyc_i, .wbm_stb_i, .wbm_we_i, .wbm_sel_i, .wbm_dat_i,
      .cmd_full_i, .wr_en_i, .clr_cnt_i(clr_cnt), .wbm_stall_o, .wr_ack_o(wr_ack),
      .accept_o(accept), .stb_cnt_o(stb_cnt), .wbuf_full_o(wbuf_full), .wr_data_o, .wr_mask_o
   );

   block_cmd_fsm i_fsm (
      .wb_clk, .mem_rst, .wbm_cyc_i, .wbm_stb_i, .wbm_we_i, .wbm_addr_i,
      .accept_i(accept), .stb_cnt_i(stb_cnt), .wbuf_full_i(wbuf_full), .cmd_full_i,
      .hit_i(hit), .rbuf_empty_i(rbuf_empty), .flush_busy_i(flush_busy), .rd_word_i(rd_word),
      .clr_cnt_o(clr_cnt), .pop_o(pop), .flush_o(flush), .flush_rd_o(flush_rd),
      .expect_addr_o(expect_addr), .rd_ack_o(rd_ack), .wbm_dat_o,
      .cmd_en_o, .cmd_instr_o, .cmd_bl_o, .cmd_addr_o
   );

   read_prefetch i_prefetch (
      .wb_clk, .mem_rst, .rd_vld_i, .rd_data_i, .pop_i(pop), .flush_i(flush),
      .flush_rd_i(flush_rd), .expect_addr_i(expect_addr), .wbm_addr_i, .hit_o(hit),
      .rbuf_empty_o(rbuf_empty), .flush_busy_o(flush_busy), .rd_word_o(rd_word)
   );

endmodule

// File: mem_port_model.sv
`include "mem_bridge_defines.svh"

module mem_port_model (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  logic                  busy_en_i,
   input  logic                  cmd_en_i,
   input  mem_bridge_pkg::cmd_t  cmd_instr_i,
   input  mem_bridge_pkg::blen_t cmd_bl_i,
   input  mem_bridge_pkg::addr_t cmd_addr_i,
   output logic                  cmd_full_o,
   output logic                  wr_en_o,
   input  mem_bridge_pkg::word_t wr_data_i,
   input  mem_bridge_pkg::mask_t wr_mask_i,
   output logic                  rd_vld_o,
   output mem_bridge_pkg::word_t rd_data_o
);
   import mem_bridge_pkg::*;

   word_t       mem [logic [26:0]];  // sparse, keyed by word index
   cmd_t        q_instr[$];          // commands wait here in order
   blen_t       q_bl[$];
   addr_t       q_addr[$];
   int          wr_left = 0;
   int          rd_left = 0;
   int          delay   = 0;
   logic [26:0] cur     = '0;

   // never written words read back as a pattern of the whole word address
   function automatic word_t fill_word(input logic [26:0] idx);
      return {idx, 5'h0} ^ 32'h6b8b_4567;
   endfunction

   initial begin
      cmd_full_o = 1'b0;
      wr_en_o    = 1'b0;
      rd_vld_o   = 1'b0;
      rd_data_o  = '0;
   end

   //////////////////////////////////////////////////
   // one command at a time, writes pulled, reads pushed
   //////////////////////////////////////////////////
   always @(negedge wb_clk) begin : serve
      word_t w;
      int    b;
      wr_en_o    <= 1'b0;  // strobes
      rd_vld_o   <= 1'b0;
      cmd_full_o <= busy_en_i && ($urandom_range(0, 3) == 0);
      if (mem_rst) begin
         wr_left = 0;
         rd_left = 0;
         q_instr.delete();
         q_bl.delete();
         q_addr.delete();
      end else begin
         if (cmd_en_i) begin  // held for a whole cycle, seen once here
            q_instr.push_back(cmd_instr_i);
            q_bl.push_back(cmd_bl_i);
            q_addr.push_back(cmd_addr_i);
         end
         if (wr_left != 0) begin
            w = mem.exists(cur) ? mem[cur] : fill_word(cur);
            for (b = 0; b < 4; b++) begin
               if (!wr_mask_i[b]) w[b*8 +: 8] = wr_data_i[b*8 +: 8];  // low bit keeps the byte
            end
            mem[cur] = w;
            wr_en_o <= 1'b1;  // head pops at the next rising edge
            cur = cur + 27'd1;
            wr_left--;
         end else if (rd_left != 0) begin
            if (delay != 0) begin
               delay--;
            end else begin
               rd_vld_o  <= 1'b1;
               rd_data_o <= mem.exists(cur) ? mem[cur] : fill_word(cur);
               cur = cur + 27'd1;
               rd_left--;
            end
         end else if (q_instr.size() != 0) begin
            cur = q_addr[0][28:2];
            if (q_instr[0] == `MB_CMD_WR) wr_left = int'(q_bl[0]) + 1;
            else rd_left = int'(q_bl[0]) + 1;
            delay = $urandom_range(0, 5);  // read latency
            void'(q_instr.pop_front());
            void'(q_bl.pop_front());
            void'(q_addr.pop_front());
         end
      end
   end

endmodule

// File: bridge_checker.sv
module bridge_checker (
   input  logic                  wb_clk,
   input  logic                  mem_rst,
   input  logic                  idle_chk_i,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  mem_bridge_pkg::mask_t sel_i,
   input  mem_bridge_pkg::addr_t addr_i,
   input  mem_bridge_pkg::word_t dat_w_i,
   input  logic                  stall_i,
   input  logic                  ack_i,
   input  mem_bridge_pkg::word_t dat_r_i,
   input  logic                  cmd_en_i,
   output int                    err_cnt_o,
   output int                    pend_o,
   output int                    rd_cnt_o
);
   import mem_bridge_pkg::*;

   word_t shadow [logic [26:0]];  // what memory should hold
   logic  q_we[$];                // one entry per accepted strobe
   word_t q_exp[$];
   addr_t q_adr[$];

   // same pattern the memory model gives unwritten words
   function automatic word_t fill_word(input logic [26:0] idx);
      return {idx, 5'h0} ^ 32'h6b8b_4567;
   endfunction

   initial begin
      err_cnt_o = 0;
      pend_o    = 0;
      rd_cnt_o  = 0;
   end

   always @(posedge wb_clk) begin : scoreboard
      logic        we_h;
      word_t       exp_h;
      addr_t       a_h;
      word_t       w;
      logic [26:0] key;
      int          b;
      if (!mem_rst) begin
         // acks first, they belong to earlier strobes
         if (ack_i) begin
            if (q_we.size() == 0) begin
               $display("acknowledge arrived with no transfer pending");
               err_cnt_o++;
            end else begin
               we_h  = q_we.pop_front();
               exp_h = q_exp.pop_front();
               a_h   = q_adr.pop_front();
               if (!we_h) begin
                  rd_cnt_o++;
                  if (dat_r_i !== exp_h) begin
                     $display("ERROR wbm_dat_o addr %h expected %h actual %h",
                              a_h, exp_h, dat_r_i);
                     err_cnt_o++;
                  end
               end
            end
         end
         if (idle_chk_i && ack_i) begin
            $display("ERROR wbm_ack_o expected %h actual %h", 1'b0, ack_i);
            err_cnt_o++;
         end
         if (idle_chk_i && cmd_en_i) begin
            $display("ERROR cmd_en_o expected %h actual %h", 1'b0, cmd_en_i);
            err_cnt_o++;
         end
         ////////////////////////////////////////////////
         // new strobes
         if (cyc_i && stb_i && !stall_i) begin
            key = addr_i[28:2];
            w   = shadow.exists(key) ? shadow[key] : fill_word(key);
            if (we_i) begin
               for (b = 0; b < 4; b++) begin
                  if (sel_i[b]) w[b*8 +: 8] = dat_w_i[b*8 +: 8];  // selected lanes only
               end
               shadow[key] = w;
            end
            q_we.push_back(we_i);
            q_exp.push_back(w);  // read value fixed at acceptance
            q_adr.push_back(addr_i);
         end
         pend_o = q_we.size();
      end
   end

endmodule

// File: tb_mem_bridge.sv
module tb_mem_bridge;
   import mem_bridge_pkg::*;

   localparam int TMO = 2000;  // cycles allowed for any single wait

   logic  wb_clk;
   logic  mem_rst;
   logic  wbm_cyc;
   logic  wbm_stb;
   logic  wbm_we;
   mask_t wbm_sel;
   addr_t wbm_addr;
   word_t wbm_dat_w;
   logic  wbm_ack;
   logic  wbm_stall;
   word_t wbm_dat_r;
   logic  cmd_en;
   cmd_t  cmd_instr;
   blen_t cmd_bl;
   addr_t cmd_addr;
   logic  cmd_full;
   logic  wr_en;
   word_t wr_data;
   mask_t wr_mask;
   logic  rd_vld;
   word_t rd_data;

   logic  busy_en;     // lets the memory model raise cmd_full at random
   logic  idle_chk;    // checker expects a quiet bus
   logic  acc_q;       // strobe accepted at the last rising edge
   logic  full_q;      // cmd_full seen at the last rising edge
   int    ack_total;
   int    err_cnt;
   int    pend_cnt;
   int    rd_cnt;
   int    tests;
   int    fails;
   logic  hung;        // set when a wait runs out

   wb_mem_bridge i_dut (
      .wb_clk, .mem_rst,
      .wbm_cyc_i(wbm_cyc), .wbm_stb_i(wbm_stb), .wbm_we_i(wbm_we), .wbm_sel_i(wbm_sel),
      .wbm_addr_i(wbm_addr), .wbm_dat_i(wbm_dat_w), .wbm_ack_o(wbm_ack),
      .wbm_stall_o(wbm_stall), .wbm_dat_o(wbm_dat_r),
      .cmd_en_o(cmd_en), .cmd_instr_o(cmd_instr), .cmd_bl_o(cmd_bl), .cmd_addr_o(cmd_addr),
      .cmd_full_i(cmd_full), .wr_en_i(wr_en), .wr_data_o(wr_data), .wr_mask_o(wr_mask),
      .rd_vld_i(rd_vld), .rd_data_i(rd_data)
   );

   mem_port_model i_mem (
      .wb_clk, .mem_rst, .busy_en_i(busy_en),
      .cmd_en_i(cmd_en), .cmd_instr_i(cmd_instr), .cmd_bl_i(cmd_bl), .cmd_addr_i(cmd_addr),
      .cmd_full_o(cmd_full), .wr_en_o(wr_en), .wr_data_i(wr_data), .wr_mask_i(wr_mask),
      .rd_vld_o(rd_vld), .rd_data_o(rd_data)
   );

   bridge_checker i_chk (
      .wb_clk, .mem_rst, .idle_chk_i(idle_chk),
      .cyc_i(wbm_cyc), .stb_i(wbm_stb), .we_i(wbm_we), .sel_i(wbm_sel), .addr_i(wbm_addr),
      .dat_w_i(wbm_dat_w), .stall_i(wbm_stall), .ack_i(wbm_ack), .dat_r_i(wbm_dat_r),
      .cmd_en_i(cmd_en), .err_cnt_o(err_cnt), .pend_o(pend_cnt), .rd_cnt_o(rd_cnt)
   );

   initial wb_clk = 1'b0;
   always #2 wb_clk = ~wb_clk;  // period 4

   // pre-edge copies for the falling-edge driver
   always @(posedge wb_clk) begin
      acc_q  <= wbm_cyc & wbm_stb & ~wbm_stall;
      full_q <= cmd_full;
      if (mem_rst) ack_total <= 0;
      else if (wbm_ack) ack_total <= ack_total + 1;
   end

   //////////////////////////////////////////////////
   // bus driver
   //////////////////////////////////////////////////
   task automatic wait_accept();
      int waited;
      waited = 0;
      do begin
         @(negedge wb_clk);
         waited++;
      end while (!acc_q && waited < TMO);
      if (!acc_q) begin
         $display("timeout: strobe at address %h was never accepted", wbm_addr);
         hung = 1'b1;
      end
   endtask

   task automatic wait_acks(input int target);
      int waited;
      waited = 0;
      while (!hung && ack_total < target && waited < TMO) begin
         @(negedge wb_clk);
         waited++;
      end
      if (!hung && ack_total < target) begin
         $display("timeout: only %0d of %0d acknowledges arrived", ack_total, target);
         hung = 1'b1;
      end
   endtask

   // let a closing write command get out before the next block
   task automatic settle();
      int waited;
      waited = 0;
      @(negedge wb_clk);
      do begin
         @(negedge wb_clk);
         waited++;
      end while (full_q && waited < TMO);
      if (full_q) begin
         $display("timeout: command port stayed full after a block");
         hung = 1'b1;
      end
   endtask

   task automatic run_block(input logic is_wr, input addr_t base, input int cnt,
                            input mask_t s, input int mode);
      int    i;
      int    acks0;
      addr_t a;
      acks0 = ack_total;
      for (i = 0; i < cnt && !hung; i++) begin
         a         = base + addr_t'(i * 4);  // sequential word addresses
         wbm_cyc   = 1'b1;
         wbm_stb   = 1'b1;
         wbm_we    = is_wr;
         wbm_addr  = a;
         wbm_sel   = s;
         wbm_dat_w = (mode == 1) ? word_t'($urandom) : {3'b101, a};
         wait_accept();
         wbm_stb = 1'b0;
         if (!is_wr) wait_acks(acks0 + i + 1);  // one read in flight at a time
      end
      wait_acks(acks0 + cnt);
      wbm_cyc = 1'b0;
      wbm_we  = 1'b0;
      if (!hung) settle();
   endtask

   task automatic run_op(input string op, input addr_t a, input int cnt,
                         input mask_t s, input int mode);
      int   err0;
      logic ok;
      err0 = err_cnt;
      ok   = 1'b1;
      if (op == "busy_on") begin
         busy_en = 1'b1;
      end else if (op == "busy_off") begin
         busy_en = 1'b0;
      end else begin
         if (op == "idle") begin
            idle_chk = 1'b1;
            repeat (cnt) @(negedge wb_clk);
            idle_chk = 1'b0;
         end else if (op == "write" || op == "read") begin
            run_block(op == "write", a, cnt, s, mode);
            // every strobe of the block must have had its acknowledge
            if (!hung && pend_cnt != 0) begin
               $display("%0d accepted strobes are still without an acknowledge", pend_cnt);
               ok = 1'b0;
            end
         end else begin
            $display("unknown operation %s in stimulus file", op);
            ok = 1'b0;
         end
         if (err_cnt != err0 || hung) ok = 1'b0;
         tests++;
         if (!ok) fails++;
         $display("test %0d %s addr %h words %0d busy %0d: %s", tests, op, a, cnt, busy_en,
                  ok ? "ok" : "FAILED");
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin : main
      int          fd;
      int          code;
      int          n;
      string       line;
      string       op;
      logic [31:0] a_in;
      int          cnt_in;
      logic [3:0]  sel_in;
      int          mode_in;
      void'($urandom(32'h4274));
      mem_rst   = 1'b1;
      wbm_cyc   = 1'b0;
      wbm_stb   = 1'b0;
      wbm_we    = 1'b0;
      wbm_sel   = '0;
      wbm_addr  = '0;
      wbm_dat_w = '0;
      busy_en   = 1'b0;
      idle_chk  = 1'b0;
      tests     = 0;
      fails     = 0;
      hung      = 1'b0;
      repeat (3) @(negedge wb_clk);  // three rising edges in reset
      mem_rst = 1'b0;
      fd = $fopen("bridge_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file bridge_stimulus.txt");
         fails++;
      end else begin
         while (!$feof(fd) && !hung) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %h %d %h %d", op, a_in, cnt_in, sel_in, mode_in);
               if (n == 5) run_op(op, addr_t'(a_in), cnt_in, sel_in, mode_in);
            end
         end
         $fclose(fd);
      end
      $display("tests %0d, failed %0d, reads checked %0d, checker errors %0d",
               tests, fails, rd_cnt, err_cnt);
      if (fails == 0 && err_cnt == 0 && !hung && tests > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: bridge_stimulus.txt
# op  addr(hex)  count(dec, cycles for idle)  sel(hex)  mode(0 fixed, 1 random)
# busy_on / busy_off switch random cmd_full, their other columns are unused
idle     00000000 12 0 0
write    00000100 1  f 1
read     00000100 1  f 0
write    00001000 20 f 0
read     00001000 20 f 0
write    00002000 4  f 1
write    00002000 4  5 1
write    00002004 2  a 1
read     00002000 4  f 0
write    00003000 16 f 1
read     00003000 2  f 0
write    00003008 4  f 1
read     00003000 10 f 0
busy_on  00000000 0  0 0
write    00004000 20 f 1
read     00004000 20 f 0
write    00004010 6  3 1
read     00004000 20 f 0
busy_off 00000000 0  0 0
read     00001000 3  f 0

// File: verilog.f
+incdir+.
mem_bridge_pkg.sv
port_fifo.sv
wb_port_front.sv
block_cmd_fsm.sv
read_prefetch.sv
wb_mem_bridge.sv
mem_port_model.sv
bridge_checker.sv
tb_mem_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_bridge
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= All tests passed!

SRCS := $(wildcard *.sv *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
